/* rename_pkg.sv */
package rename_pkg;

    // Architectural integer register file
    localparam int NUM_AREGS = 32;
    localparam int AREG_W    = 5;                // log2 of NUM_AREGS

    typedef logic [AREG_W-1:0] areg_t;           // x0..x31 index

    // Default sizes, the top level passes them down
    localparam int NUM_PREGS_DEF = 64;           // Physical registers
    localparam int NUM_CKPT_DEF  = 4;            // Must be a power of two
    localparam int NUM_WB_DEF    = 2;            // Writeback lanes

endpackage

/* rename_ctrl.sv */
`timescale 1ns/1ps

module rename_ctrl (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              req_valid_i,      // Rename request from decode
    input  logic              write_rd_i,       // Instruction writes rd
    input  rename_pkg::areg_t rd_i,
    input  logic              ckpt_req_i,       // Branch asks for a checkpoint
    input  logic              recover_i,        // Mispredict, go back to a checkpoint
    input  logic              recover_commit_i, // Exception, go back to commit state
    input  logic              free_empty_i,     // No physical register left
    input  logic              ckpt_full_i,      // No checkpoint slot left
    output logic              rename_en_o,
    output logic              alloc_en_o,
    output logic              ckpt_en_o,
    output logic              stall_o
);

    localparam logic RUN     = 1'b0;
    localparam logic RECOVER = 1'b1;

    logic state_q;
    logic state_d;
    logic recovering;

    assign recovering = recover_i | recover_commit_i;

    always_comb begin
        state_d = state_q;
        if (recovering) begin
            state_d = RECOVER;                  // Tables restored on this edge
        end else if (state_q == RECOVER) begin
            state_d = RUN;                      // Single bubble
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Stall from state and resource flags only
    assign stall_o = (state_q == RECOVER) | free_empty_i | ckpt_full_i;

    // A cycle that carries a recovery strobe renames nothing
    assign rename_en_o = req_valid_i & ~stall_o & ~recovering;
    assign alloc_en_o  = rename_en_o & write_rd_i & (rd_i != '0); // x0 takes no register
    assign ckpt_en_o   = rename_en_o & ckpt_req_i;

endmodule

/* checkpoint_counter.sv */
`timescale 1ns/1ps

module checkpoint_counter #(
    parameter  int NUM_CKPT = rename_pkg::NUM_CKPT_DEF,
    localparam int CKPT_W   = $clog2(NUM_CKPT)
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              ckpt_en_i,        // Take a checkpoint this cycle
    input  logic              delete_ckpt_i,    // Oldest branch resolved
    input  logic              recover_i,
    input  logic [CKPT_W-1:0] recover_ckpt_i,   // Label to go back to
    input  logic              recover_commit_i,
    output logic [CKPT_W-1:0] head_o,           // Working copy index
    output logic              full_o
);

    logic [CKPT_W-1:0] head_q;
    logic [CKPT_W-1:0] tail_q;
    logic [CKPT_W-1:0] tail_d;
    logic [CKPT_W:0]   count_q;                 // One bit wider than pointers

    assign tail_d = tail_q + CKPT_W'(delete_ckpt_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (recover_commit_i) begin
            // Every checkpoint is dropped
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (recover_i) begin
            head_q  <= recover_ckpt_i;
            tail_q  <= tail_d;
            count_q <= {1'b0, recover_ckpt_i - tail_d}; // Ring distance, power of two wraps
        end else begin
            head_q  <= head_q + CKPT_W'(ckpt_en_i);
            tail_q  <= tail_d;
            count_q <= count_q + (CKPT_W+1)'(ckpt_en_i) - (CKPT_W+1)'(delete_ckpt_i);
        end
    end

    assign head_o = head_q;

    // Last slot is the working copy, so one less than the ring size
    assign full_o = (count_q == (CKPT_W+1)'(NUM_CKPT - 1));

endmodule

/* free_list.sv */
`timescale 1ns/1ps

module free_list #(
    parameter  int NUM_PREGS = rename_pkg::NUM_PREGS_DEF,
    parameter  int NUM_CKPT  = rename_pkg::NUM_CKPT_DEF,
    localparam int PREG_W    = $clog2(NUM_PREGS),
    localparam int CKPT_W    = $clog2(NUM_CKPT)
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              alloc_en_i,       // Pop one register
    input  logic              ckpt_en_i,
    input  logic [CKPT_W-1:0] head_i,           // Current checkpoint slot
    input  logic              recover_i,
    input  logic [CKPT_W-1:0] recover_ckpt_i,
    input  logic              recover_commit_i,
    input  logic              commit_write_i,   // Commit of an instruction that wrote rd
    input  logic [PREG_W-1:0] commit_free_preg_i, // Old mapping, now free
    output logic [PREG_W-1:0] alloc_preg_o,
    output logic              empty_o
);

    // Never more than NUM_PREGS-32 free at once, depth is a power of two
    localparam int FL_DEPTH = NUM_PREGS - rename_pkg::NUM_AREGS;
    localparam int FL_W     = $clog2(FL_DEPTH);

    logic [PREG_W-1:0] fifo_q     [FL_DEPTH];
    logic [FL_W:0]     ckpt_rd_q  [NUM_CKPT];   // Read pointer per checkpoint
    logic [FL_W:0]     rd_ptr_q;                // Extra wrap bit on all pointers
    logic [FL_W:0]     wr_ptr_q;
    logic [FL_W:0]     commit_rd_q;             // Read pointer as seen at commit
    logic [FL_W:0]     rd_ptr_nxt;

    assign rd_ptr_nxt   = rd_ptr_q + (FL_W+1)'(alloc_en_i);
    assign alloc_preg_o = fifo_q[rd_ptr_q[FL_W-1:0]];
    assign empty_o      = (rd_ptr_q == wr_ptr_q);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_ptr_q    <= '0;
            wr_ptr_q    <= {1'b1, FL_W'(0)};    // Full, 32 up to NUM_PREGS-1
            commit_rd_q <= '0;
        end else begin
            if (recover_commit_i) begin
                rd_ptr_q <= commit_rd_q;
            end else if (recover_i) begin
                rd_ptr_q <= ckpt_rd_q[recover_ckpt_i];
            end else begin
                rd_ptr_q <= rd_ptr_nxt;
            end
            if (commit_write_i) begin
                wr_ptr_q    <= wr_ptr_q + 1'b1;
                commit_rd_q <= commit_rd_q + 1'b1; // Committed rd consumed one entry
            end
        end
    end

    // Snapshot slot keeps the pointer after this cycle's pop
    always_ff @(posedge clk_i) begin
        if (ckpt_en_i) begin
            ckpt_rd_q[head_i] <= rd_ptr_nxt;
        end
    end

    // Register storage, loaded with the initial free set
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo_q[i] <= PREG_W'(rename_pkg::NUM_AREGS + i);
            end
        end else if (commit_write_i) begin
            fifo_q[wr_ptr_q[FL_W-1:0]] <= commit_free_preg_i;
        end
    end

endmodule

/* rename_table.sv */
`timescale 1ns/1ps

module rename_table #(
    parameter  int NUM_PREGS = rename_pkg::NUM_PREGS_DEF,
    parameter  int NUM_CKPT  = rename_pkg::NUM_CKPT_DEF,
    parameter  int NUM_WB    = rename_pkg::NUM_WB_DEF,
    localparam int PREG_W    = $clog2(NUM_PREGS),
    localparam int CKPT_W    = $clog2(NUM_CKPT)
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          rename_en_i,   // Lookup this cycle
    input  logic                          alloc_en_i,    // Write new rd mapping
    input  logic                          ckpt_en_i,
    input  logic [CKPT_W-1:0]             head_i,        // Working copy
    input  rename_pkg::areg_t             rs1_i,
    input  rename_pkg::areg_t             rs2_i,
    input  rename_pkg::areg_t             rd_i,
    input  logic                          use_rs1_i,
    input  logic                          use_rs2_i,
    input  logic [PREG_W-1:0]             new_preg_i,    // From free list head
    input  logic [NUM_WB-1:0]             wb_valid_i,
    input  rename_pkg::areg_t [NUM_WB-1:0] wb_areg_i,
    input  logic [NUM_WB-1:0][PREG_W-1:0] wb_preg_i,
    input  logic                          recover_commit_i,
    input  logic                          commit_write_i,
    input  rename_pkg::areg_t             commit_areg_i,
    input  logic [PREG_W-1:0]             commit_preg_i,
    output logic                          ren_valid_o,
    output logic [PREG_W-1:0]             prs1_o,
    output logic                          rdy1_o,
    output logic [PREG_W-1:0]             prs2_o,
    output logic                          rdy2_o,
    output logic [PREG_W-1:0]             prd_o,
    output logic [PREG_W-1:0]             old_prd_o,
    output logic [CKPT_W-1:0]             ckpt_o         // Label for this branch
);

    localparam int NA = rename_pkg::NUM_AREGS;

    logic [PREG_W-1:0] map_q    [NUM_CKPT][NA];  // One mapping copy per slot
    logic              rdy_q    [NUM_CKPT][NA];
    logic [PREG_W-1:0] commit_q [NA];            // Architectural state
    logic              rdy_cur  [NA];            // Working copy plus writeback bypass
    logic [CKPT_W-1:0] head_nxt;

    assign head_nxt = head_i + 1'b1;             // Wraps, ring is a power of two

    always_comb begin
        for (int a = 0; a < NA; a++) begin
            rdy_cur[a] = rdy_q[head_i][a];
            for (int w = 0; w < NUM_WB; w++) begin
                if (wb_valid_i[w] && (wb_areg_i[w] == rename_pkg::areg_t'(a)) &&
                    (wb_preg_i[w] == map_q[head_i][a])) begin
                    rdy_cur[a] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Identity map, all ready
            for (int k = 0; k < NUM_CKPT; k++) begin
                for (int a = 0; a < NA; a++) begin
                    map_q[k][a] <= PREG_W'(a);
                    rdy_q[k][a] <= 1'b1;
                end
            end
            for (int a = 0; a < NA; a++) begin
                commit_q[a] <= PREG_W'(a);
            end
        end else begin
            if (recover_commit_i) begin
                // Head returns to slot 0 on the same edge
                for (int a = 0; a < NA; a++) begin
                    map_q[0][a] <= commit_q[a];
                    rdy_q[0][a] <= 1'b1;
                end
            end else begin
                // Writeback marks every copy that still holds the mapping
                for (int w = 0; w < NUM_WB; w++) begin
                    for (int k = 0; k < NUM_CKPT; k++) begin
                        if (wb_valid_i[w] && (map_q[k][wb_areg_i[w]] == wb_preg_i[w])) begin
                            rdy_q[k][wb_areg_i[w]] <= 1'b1;
                        end
                    end
                end
                // Next slot becomes the working copy, current one freezes
                if (ckpt_en_i) begin
                    for (int a = 0; a < NA; a++) begin
                        map_q[head_nxt][a] <= map_q[head_i][a];
                        rdy_q[head_nxt][a] <= rdy_cur[a];
                    end
                end
                // New rd last so it wins over the copy and writeback
                if (alloc_en_i) begin
                    map_q[head_i][rd_i] <= new_preg_i;
                    rdy_q[head_i][rd_i] <= 1'b0;
                    if (ckpt_en_i) begin
                        map_q[head_nxt][rd_i] <= new_preg_i;
                        rdy_q[head_nxt][rd_i] <= 1'b0;
                    end
                end
            end
            if (commit_write_i && (commit_areg_i != '0)) begin
                commit_q[commit_areg_i] <= commit_preg_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ren_valid_o <= 1'b0;
        end else begin
            ren_valid_o <= rename_en_i;      // Result one cycle after accept
        end
    end

    // Lookup results, read before this cycle's write
    always_ff @(posedge clk_i) begin
        if (rename_en_i) begin
            prs1_o    <= map_q[head_i][rs1_i];
            rdy1_o    <= rdy_cur[rs1_i] | ~use_rs1_i;  // Unused source counts as ready
            prs2_o    <= map_q[head_i][rs2_i];
            rdy2_o    <= rdy_cur[rs2_i] | ~use_rs2_i;
            prd_o     <= alloc_en_i ? new_preg_i : map_q[head_i][rd_i];
            old_prd_o <= map_q[head_i][rd_i];      // Freed when this one commits
            ckpt_o    <= head_i;
        end
    end

endmodule

/* rename_top.sv */
`timescale 1ns/1ps

module rename_top #(
    parameter  int NUM_PREGS = rename_pkg::NUM_PREGS_DEF,
    parameter  int NUM_CKPT  = rename_pkg::NUM_CKPT_DEF,
    parameter  int NUM_WB    = rename_pkg::NUM_WB_DEF,
    localparam int PREG_W    = $clog2(NUM_PREGS),
    localparam int CKPT_W    = $clog2(NUM_CKPT)
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          req_valid_i,
    input  rename_pkg::areg_t             rs1_i,
    input  rename_pkg::areg_t             rs2_i,
    input  rename_pkg::areg_t             rd_i,
    input  logic                          use_rs1_i,
    input  logic                          use_rs2_i,
    input  logic                          write_rd_i,
    input  logic                          ckpt_req_i,
    input  logic [NUM_WB-1:0]             wb_valid_i,
    input  rename_pkg::areg_t [NUM_WB-1:0] wb_areg_i,
    input  logic [NUM_WB-1:0][PREG_W-1:0] wb_preg_i,
    input  logic                          commit_i,
    input  logic                          commit_write_i,
    input  rename_pkg::areg_t             commit_areg_i,
    input  logic [PREG_W-1:0]             commit_preg_i,
    input  logic [PREG_W-1:0]             commit_free_preg_i,
    input  logic                          recover_i,
    input  logic [CKPT_W-1:0]             recover_ckpt_i,
    input  logic                          delete_ckpt_i,
    input  logic                          recover_commit_i,
    output logic                          ren_valid_o,
    output logic [PREG_W-1:0]             prs1_o,
    output logic                          rdy1_o,
    output logic [PREG_W-1:0]             prs2_o,
    output logic                          rdy2_o,
    output logic [PREG_W-1:0]             prd_o,
    output logic [PREG_W-1:0]             old_prd_o,
    output logic [CKPT_W-1:0]             ckpt_o,
    output logic                          stall_o
);

    logic              rename_en;
    logic              alloc_en;
    logic              ckpt_en;
    logic              free_empty;
    logic              ckpt_full;
    logic [CKPT_W-1:0] head;
    logic [PREG_W-1:0] alloc_preg;
    logic              commit_wr;

    assign commit_wr = commit_i & commit_write_i;  // Only real commits touch state

    rename_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_valid_i      (req_valid_i),
        .write_rd_i       (write_rd_i),
        .rd_i             (rd_i),
        .ckpt_req_i       (ckpt_req_i),
        .recover_i        (recover_i),
        .recover_commit_i (recover_commit_i),
        .free_empty_i     (free_empty),
        .ckpt_full_i      (ckpt_full),
        .rename_en_o      (rename_en),
        .alloc_en_o       (alloc_en),
        .ckpt_en_o        (ckpt_en),
        .stall_o          (stall_o)
    );

    checkpoint_counter #(.NUM_CKPT(NUM_CKPT)) u_ckpt_cnt (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .ckpt_en_i        (ckpt_en),
        .delete_ckpt_i    (delete_ckpt_i),
        .recover_i        (recover_i),
        .recover_ckpt_i   (recover_ckpt_i),
        .recover_commit_i (recover_commit_i),
        .head_o           (head),
        .full_o           (ckpt_full)
    );

    free_list #(.NUM_PREGS(NUM_PREGS), .NUM_CKPT(NUM_CKPT)) u_free_list (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .alloc_en_i         (alloc_en),
        .ckpt_en_i          (ckpt_en),
        .head_i             (head),
        .recover_i          (recover_i),
        .recover_ckpt_i     (recover_ckpt_i),
        .recover_commit_i   (recover_commit_i),
        .commit_write_i     (commit_wr),
        .commit_free_preg_i (commit_free_preg_i),
        .alloc_preg_o       (alloc_preg),
        .empty_o            (free_empty)
    );

    rename_table #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_CKPT  (NUM_CKPT),
        .NUM_WB    (NUM_WB)
    ) u_table (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .rename_en_i      (rename_en),
        .alloc_en_i       (alloc_en),
        .ckpt_en_i        (ckpt_en),
        .head_i           (head),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .rd_i             (rd_i),
        .use_rs1_i        (use_rs1_i),
        .use_rs2_i        (use_rs2_i),
        .new_preg_i       (alloc_preg),
        .wb_valid_i       (wb_valid_i),
        .wb_areg_i        (wb_areg_i),
        .wb_preg_i        (wb_preg_i),
        .recover_commit_i (recover_commit_i),
        .commit_write_i   (commit_wr),
        .commit_areg_i    (commit_areg_i),
        .commit_preg_i    (commit_preg_i),
        .ren_valid_o      (ren_valid_o),
        .prs1_o           (prs1_o),
        .rdy1_o           (rdy1_o),
        .prs2_o           (prs2_o),
        .rdy2_o           (rdy2_o),
        .prd_o            (prd_o),
        .old_prd_o        (old_prd_o),
        .ckpt_o           (ckpt_o)
    );

endmodule

/* tb_rename_top.sv */
`timescale 1ns/1ps

module tb_rename_top;

    localparam int NUM_PREGS  = rename_pkg::NUM_PREGS_DEF;
    localparam int NUM_CKPT   = rename_pkg::NUM_CKPT_DEF;
    localparam int NUM_WB     = rename_pkg::NUM_WB_DEF;
    localparam int NA         = rename_pkg::NUM_AREGS;
    localparam int PREG_W     = $clog2(NUM_PREGS);
    localparam int CKPT_W     = $clog2(NUM_CKPT);
    // Reset and six phases plus margin
    localparam int MAX_CYCLES = 10 + 10 + 25 + 20 + 15 + 50 + 50 + 120;

    logic                          clk_i = 1'b0;
    logic                          rstn_i;
    logic                          req_valid_i;
    rename_pkg::areg_t             rs1_i;
    rename_pkg::areg_t             rs2_i;
    rename_pkg::areg_t             rd_i;
    logic                          use_rs1_i;
    logic                          use_rs2_i;
    logic                          write_rd_i;
    logic                          ckpt_req_i;
    logic [NUM_WB-1:0]             wb_valid_i;
    rename_pkg::areg_t [NUM_WB-1:0] wb_areg_i;
    logic [NUM_WB-1:0][PREG_W-1:0] wb_preg_i;
    logic                          commit_i;
    logic                          commit_write_i;
    rename_pkg::areg_t             commit_areg_i;
    logic [PREG_W-1:0]             commit_preg_i;
    logic [PREG_W-1:0]             commit_free_preg_i;
    logic                          recover_i;
    logic [CKPT_W-1:0]             recover_ckpt_i;
    logic                          delete_ckpt_i;
    logic                          recover_commit_i;
    logic                          ren_valid_o;
    logic [PREG_W-1:0]             prs1_o;
    logic                          rdy1_o;
    logic [PREG_W-1:0]             prs2_o;
    logic                          rdy2_o;
    logic [PREG_W-1:0]             prd_o;
    logic [PREG_W-1:0]             old_prd_o;
    logic [CKPT_W-1:0]             ckpt_o;
    logic                          stall_o;

    // Reference model
    int map [NA];                 // Working mapping
    bit rdy [NA];
    int cmap [NA];                // Committed mapping
    int ck_map [NUM_CKPT][NA];    // Snapshot per label
    bit ck_rdy [NUM_CKPT][NA];
    int ck_rd [NUM_CKPT];         // Free list read index at checkpoint
    int ck_rob [NUM_CKPT];        // In-flight count at checkpoint
    int fl [$];                   // Every register ever put on the free list in order
    int rob [$];                  // In flight writes as {rd, new, old} bytes
    int fl_rd = 0;
    int commit_rd = 0;
    int head = 0;
    int tail = 0;
    int count = 0;
    bit in_recover = 1'b0;

    // Expected rename result while pending
    int exp_prs1;
    bit exp_rdy1;
    int exp_prs2;
    bit exp_rdy2;
    int exp_prd;
    int exp_old;
    int exp_ckpt;
    bit pending = 1'b0;

    int errors = 0;
    int checked = 0;
    int cycles = 0;
    int seed = 32'h53db;

    rename_top #(.NUM_PREGS(NUM_PREGS), .NUM_CKPT(NUM_CKPT), .NUM_WB(NUM_WB)) dut (.*);

    always #5 clk_i = ~clk_i;

    function automatic int rand_areg();
        return $unsigned($random(seed)) % NA;
    endfunction

    function automatic bit expected_stall();
        return in_recover || (fl_rd == fl.size()) || (count == NUM_CKPT - 1);
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // One rename with the model updated after the accepting edge
    task automatic rename(input int rs1, input int rs2, input int rd, input bit wr, input bit ck);
        while (stall_o) begin
            idle(1);
        end
        req_valid_i = 1'b1;
        rs1_i       = rename_pkg::areg_t'(rs1);
        rs2_i       = rename_pkg::areg_t'(rs2);
        rd_i        = rename_pkg::areg_t'(rd);
        use_rs1_i   = (rs1 % 5 != 4);
        use_rs2_i   = (rs2 % 3 != 0);           // Mix of used and unused sources
        write_rd_i  = wr;
        ckpt_req_i  = ck;
        idle(1);
        req_valid_i = 1'b0;
        ckpt_req_i  = 1'b0;
        exp_prs1 = map[rs1];
        exp_rdy1 = rdy[rs1] || !use_rs1_i;
        exp_prs2 = map[rs2];
        exp_rdy2 = rdy[rs2] || !use_rs2_i;
        exp_old  = map[rd];
        exp_ckpt = head;
        pending  = 1'b1;
        if (wr && rd != 0) begin                // x0 takes nothing
            map[rd] = fl[fl_rd];
            rdy[rd] = 1'b0;
            rob.push_back((rd << 16) | (map[rd] << 8) | exp_old);
            fl_rd++;
        end
        exp_prd = map[rd];
        if (ck) begin
            ck_map[head] = map;                 // Snapshot includes this rename
            ck_rdy[head] = rdy;
            ck_rd[head]  = fl_rd;
            ck_rob[head] = rob.size();
            head = (head + 1) % NUM_CKPT;
            count++;
        end
    endtask

    // Ready in the working map and in every snapshot with the same mapping
    function automatic void mark_ready(input int areg);
        for (int k = 0; k < NUM_CKPT; k++) begin
            if (ck_map[k][areg] == map[areg]) begin
                ck_rdy[k][areg] = 1'b1;
            end
        end
        rdy[areg] = 1'b1;
    endfunction

    task automatic writeback(input int areg);
        int lane;
        lane = $unsigned($random(seed)) % NUM_WB;
        wb_valid_i[lane] = 1'b1;
        wb_areg_i[lane]  = rename_pkg::areg_t'(areg);
        wb_preg_i[lane]  = PREG_W'(map[areg]);
        idle(1);
        wb_valid_i = '0;
        mark_ready(areg);
    endtask

    // Writing rename whose lookup meets a writeback in the same cycle
    task automatic rename_during_writeback(input int rs1, input int rs2, input int rd,
                                           input int wb_areg);
        wb_valid_i[0] = 1'b1;
        wb_areg_i[0]  = rename_pkg::areg_t'(wb_areg);
        wb_preg_i[0]  = PREG_W'(map[wb_areg]);
        mark_ready(wb_areg);                    // Bypass makes it visible now
        rename(rs1, rs2, rd, 1'b1, 1'b0);
        wb_valid_i = '0;
    endtask

    task automatic commit_oldest();
        int e;
        e = rob.pop_front();
        commit_i           = 1'b1;
        commit_write_i     = 1'b1;
        commit_areg_i      = rename_pkg::areg_t'(e >> 16);
        commit_preg_i      = PREG_W'((e >> 8) & 8'hff);
        commit_free_preg_i = PREG_W'(e & 8'hff);
        idle(1);
        commit_i       = 1'b0;
        commit_write_i = 1'b0;
        cmap[e >> 16] = (e >> 8) & 8'hff;
        fl.push_back(e & 8'hff);                // Old mapping returns to the pool
        commit_rd++;
    endtask

    task automatic delete_oldest_ckpt();
        delete_ckpt_i = 1'b1;
        idle(1);
        delete_ckpt_i = 1'b0;
        tail = (tail + 1) % NUM_CKPT;
        count--;
    endtask

    // Mispredict to a label or exception back to committed state
    task automatic recover(input bit to_commit, input int label);
        recover_i        = !to_commit;
        recover_commit_i = to_commit;
        recover_ckpt_i   = CKPT_W'(label);
        idle(1);
        recover_i        = 1'b0;
        recover_commit_i = 1'b0;
        if (to_commit) begin
            map = cmap;
            rdy = '{default: 1'b1};
            fl_rd = commit_rd;
            rob.delete();
            head  = 0;
            tail  = 0;
            count = 0;
        end else begin
            map = ck_map[label];
            rdy = ck_rdy[label];
            fl_rd = ck_rd[label];
            while (rob.size() > ck_rob[label]) begin
                void'(rob.pop_back());          // Squash younger writes
            end
            head  = label;
            count = (label - tail + NUM_CKPT) % NUM_CKPT;
        end
        in_recover = 1'b1;
        idle(1);
        in_recover = 1'b0;                      // One bubble only
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rstn_i) begin
            assert (ren_valid_o == pending)
                else report_mismatch("ren_valid_o", pending, ren_valid_o);
            assert (stall_o == expected_stall())
                else report_mismatch("stall_o", expected_stall(), stall_o);
            if (ren_valid_o && pending) begin
                checked++;
                assert (prs1_o == exp_prs1) else report_mismatch("prs1_o", exp_prs1, prs1_o);
                assert (rdy1_o == exp_rdy1) else report_mismatch("rdy1_o", exp_rdy1, rdy1_o);
                assert (prs2_o == exp_prs2) else report_mismatch("prs2_o", exp_prs2, prs2_o);
                assert (rdy2_o == exp_rdy2) else report_mismatch("rdy2_o", exp_rdy2, rdy2_o);
                assert (prd_o == exp_prd) else report_mismatch("prd_o", exp_prd, prd_o);
                assert (old_prd_o == exp_old) else report_mismatch("old_prd_o", exp_old, old_prd_o);
                assert (ckpt_o == exp_ckpt) else report_mismatch("ckpt_o", exp_ckpt, ckpt_o);
            end
            pending = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int lbl;
        {req_valid_i, use_rs1_i, use_rs2_i, write_rd_i, ckpt_req_i} = '0;
        {rs1_i, rs2_i, rd_i, recover_ckpt_i} = '0;
        {wb_valid_i, wb_areg_i, wb_preg_i} = '0;
        {commit_i, commit_write_i, commit_areg_i, commit_preg_i, commit_free_preg_i} = '0;
        {recover_i, delete_ckpt_i, recover_commit_i} = '0;
        for (int a = 0; a < NA; a++) begin
            map[a]  = a;                        // Identity map with all ready
            rdy[a]  = 1'b1;
            cmap[a] = a;
        end
        for (int p = NA; p < NUM_PREGS; p++) begin
            fl.push_back(p);
        end
        rstn_i = 1'b0;
        idle(10);
        rstn_i = 1'b1;
        // Identity lookups after reset
        repeat (6) rename(rand_areg(), rand_areg(), rand_areg(), 1'b0, 1'b0);
        // Writes take free registers in order
        repeat (8) rename(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b0);
        rename(3, 4, 0, 1'b1, 1'b0);
        rename(7, 0, 7, 1'b1, 1'b0);
        rename(7, 7, 0, 1'b0, 1'b0);            // x7 not ready yet
        writeback(7);
        rename(7, 7, 0, 1'b0, 1'b0);
        repeat (4) writeback(rand_areg());
        // Checkpoint and speculate before a mispredict
        lbl = head;
        rename(rand_areg(), rand_areg(), 5, 1'b1, 1'b1);
        rename(5, 6, 6, 1'b1, 1'b0);
        rename_during_writeback(6, 5, 5, 5);    // Checkpointed x5 becomes ready too
        writeback(5);
        rename(9, 5, 9, 1'b1, 1'b0);
        recover(1'b0, lbl);
        rename(5, 6, 9, 1'b1, 1'b0);
        rename(9, 5, 0, 1'b0, 1'b0);
        // Checkpoint ring fills up
        repeat (NUM_CKPT - 1) rename(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b1);
        idle(3);
        delete_oldest_ckpt();
        rename(rand_areg(), rand_areg(), rand_areg(), 1'b1, 1'b1);
        repeat (NUM_CKPT - 1) delete_oldest_ckpt();
        // Drain the free list
        while (fl_rd < fl.size()) begin
            rename(rand_areg(), rand_areg(), 1 + rand_areg() % (NA - 1), 1'b1, 1'b0);
        end
        idle(3);
        repeat (3) commit_oldest();
        // Exception back to the committed state
        repeat (3) rename(rand_areg(), rand_areg(), 1 + rand_areg() % (NA - 1), 1'b1, 1'b0);
        repeat (4) commit_oldest();
        recover(1'b1, 0);
        for (int a = 0; a < NA; a += 2) begin
            rename(a, a + 1, 0, 1'b0, 1'b0);
        end
        repeat (3) rename(rand_areg(), rand_areg(), 1 + rand_areg() % (NA - 1), 1'b1, 1'b0);
        idle(2);
        $display("Renames checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
rename_pkg.sv
rename_ctrl.sv
checkpoint_counter.sv
free_list.sv
rename_table.sv
rename_top.sv
tb_rename_top.sv

/* Bender.yml */
package:
  name: rename_stage

sources:
  - rename_pkg.sv
  - rename_ctrl.sv
  - checkpoint_counter.sv
  - free_list.sv
  - rename_table.sv
  - rename_top.sv
  - target: simulation
    files:
      - tb_rename_top.sv
